//--- Makefile
# Verilator lint and simulation of the data cache

TOP := dcache_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f dcache.f

# the run log decides pass or fail
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f dcache.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dcache.f
source/dcache_pkg.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_ctrl.sv
source/dcache_top.sv
testbench/dcache_mem_model.sv
testbench/dcache_sva.sv
testbench/dcache_tb.sv

//--- source/dcache_ctrl.sv
`timescale 1ns/1ns

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int  index_width  = default_index_width,
    parameter int  offset_width = default_offset_width,
    localparam int tag_width    = 32 - index_width - offset_width - 2,
    localparam int line_width   = 32 << offset_width,
    localparam int index_lsb    = offset_width + 2
) (
    input  logic                    clk,
    input  logic                    reset,
    // pipeline
    input  logic                    req_valid,
    input  cache_req_t              req,
    output logic                    req_ready,
    output logic                    resp_valid,
    output word_t                   rdata,
    input  word_t                   hit_word,
    // tag store
    input  logic [1:0]              hit,
    input  logic                    victim,
    output logic [index_width-1:0]  lookup_index,
    output logic [tag_width-1:0]    lookup_tag,
    output logic [index_width-1:0]  wr_index,
    output logic [tag_width-1:0]    wr_tag,
    output logic [1:0]              tag_we,
    output logic                    inv_set,
    output logic                    touch,
    output logic                    touch_way,
    // data store
    output logic [offset_width-1:0] wr_offset,
    output word_t                   wr_word,
    output strb_t                   wr_strb,
    output logic [1:0]              data_word_we,
    output logic [1:0]              data_line_we,
    // memory
    output logic                    mem_req_valid,
    output mem_req_t                mem_req,
    input  logic                    mem_addr_ok,
    input  logic                    mem_data_ok,
    input  logic [line_width-1:0]   mem_rdata
);

    typedef enum logic [2:0] {
        idle,
        lookup,
        mem_wait_addr,
        mem_wait_data,
        respond
    } state_e;

    state_e     state;
    state_e     state_next;
    cache_req_t rbuf;
    addr_t      cur_addr;
    logic       accept;
    logic       is_read;
    logic       is_write;
    logic       is_inval;
    logic       fill_req;
    logic       in_lookup;
    logic       data_back;
    logic       fill_done;
    logic [1:0] victim_mask;

    ////////////////////////////////////////////////////////////
    // request buffer
    ////////////////////////////////////////////////////////////

    assign req_ready = (state == idle);
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (accept) begin
            rbuf <= req;
        end
    end

    assign is_read  = (rbuf.kind == kind_read);
    assign is_write = (rbuf.kind == kind_write);
    assign is_inval = (rbuf.kind == kind_invalidate);
    assign fill_req = is_read && !rbuf.uncached;

    // arrays are addressed by the incoming request while idle
    assign cur_addr     = req_ready ? req.addr : rbuf.addr;
    assign lookup_index = cur_addr[index_lsb +: index_width];
    assign lookup_tag   = cur_addr[31 -: tag_width];

    assign wr_index  = rbuf.addr[index_lsb +: index_width];
    assign wr_tag    = rbuf.addr[31 -: tag_width];
    assign wr_offset = rbuf.addr[2 +: offset_width];
    assign wr_word   = rbuf.wdata;
    assign wr_strb   = rbuf.wstrb;

    ////////////////////////////////////////////////////////////
    // main FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (accept) begin
                    // uncached accesses skip the arrays entirely
                    if (req.uncached && req.kind != kind_invalidate) begin
                        state_next = mem_wait_addr;
                    end else begin
                        state_next = lookup;
                    end
                end
            end
            lookup: begin
                if (is_inval) begin
                    state_next = idle;
                end else if (is_read && |hit) begin
                    state_next = respond;
                end else begin
                    // read miss or any write
                    state_next = mem_wait_addr;
                end
            end
            mem_wait_addr: begin
                if (mem_addr_ok) begin
                    state_next = mem_wait_data;
                end
            end
            mem_wait_data: begin
                if (mem_data_ok) begin
                    state_next = is_write ? idle : respond;
                end
            end
            respond: begin
                state_next = idle;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // store controls
    ////////////////////////////////////////////////////////////

    assign in_lookup   = (state == lookup);
    assign data_back   = (state == mem_wait_data) && mem_data_ok;
    assign fill_done   = data_back && fill_req;
    assign victim_mask = victim ? 2'b10 : 2'b01;

    assign inv_set      = in_lookup && is_inval;
    // a write hit updates the line and a write miss leaves it alone
    assign data_word_we = (in_lookup && is_write) ? hit : 2'b00;
    assign data_line_we = fill_done ? victim_mask : 2'b00;
    assign tag_we       = fill_done ? victim_mask : 2'b00;

    assign touch     = (in_lookup && !is_inval && |hit) || fill_done;
    assign touch_way = fill_done ? victim : hit[1];

    ////////////////////////////////////////////////////////////
    // memory request and response word
    ////////////////////////////////////////////////////////////

    assign mem_req_valid = (state == mem_wait_addr);

    always_comb begin
        mem_req.write = is_write;
        mem_req.line  = fill_req;
        mem_req.addr  = rbuf.addr;
        mem_req.wdata = rbuf.wdata;
        mem_req.wstrb = rbuf.wstrb;
        if (fill_req) begin
            mem_req.addr[index_lsb-1:0] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_lookup) begin
            rdata <= hit_word;
        end else if (data_back) begin
            // uncached words come back in the low lane
            rdata <= rbuf.uncached ? mem_rdata[31:0] : mem_rdata[32*wr_offset +: 32];
        end
    end

    assign resp_valid = (state == respond);

endmodule

//--- source/dcache_data_store.sv
`timescale 1ns/1ns

module dcache_data_store
    import dcache_pkg::*;
#(
    parameter int  index_width  = default_index_width,
    parameter int  offset_width = default_offset_width,
    localparam int line_width   = 32 << offset_width,
    localparam int num_sets     = 1 << index_width
) (
    input  logic                    clk,
    input  logic [index_width-1:0]  rd_index,
    output logic [line_width-1:0]   line0,
    output logic [line_width-1:0]   line1,
    input  logic [index_width-1:0]  wr_index,
    input  logic [offset_width-1:0] wr_offset,
    input  word_t                   wr_word,
    input  strb_t                   wr_strb,
    input  logic [1:0]              word_we,
    input  logic [1:0]              line_we,
    input  logic [line_width-1:0]   wr_line
);

    // one array per way indexed by set
    logic [line_width-1:0] lines [2][num_sets];

    ////////////////////////////////////////////////////////////
    // writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (line_we[w]) begin
                // refill replaces the whole line
                lines[w][wr_index] <= wr_line;
            end else if (word_we[w]) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr_strb[b]) begin
                        lines[w][wr_index][32*wr_offset + 8*b +: 8] <= wr_word[8*b +: 8];
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // synchronous read of both ways
    ////////////////////////////////////////////////////////////

    // data shows up in the cycle after the index is presented
    always_ff @(posedge clk) begin
        line0 <= lines[0][rd_index];
        line1 <= lines[1][rd_index];
    end

endmodule

//--- source/dcache_pkg.sv
package dcache_pkg;

    ////////////////////////////////////////////////////////////
    // basic widths
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    // geometry defaults that the top level overrides
    localparam int default_index_width  = 4;
    localparam int default_offset_width = 2;

    ////////////////////////////////////////////////////////////
    // pipeline side
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        kind_read       = 2'd0,
        kind_write      = 2'd1,
        kind_invalidate = 2'd2
    } req_kind_e;

    // invalidate uses only the index bits of addr
    typedef struct packed {
        req_kind_e kind;
        logic      uncached;
        addr_t     addr;
        word_t     wdata;
        strb_t     wstrb;
    } cache_req_t;

    ////////////////////////////////////////////////////////////
    // memory side
    ////////////////////////////////////////////////////////////

    // a line fill has the offset bits of addr cleared
    typedef struct packed {
        logic  write;
        logic  line;
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
    } mem_req_t;

endpackage

//--- source/dcache_tag_store.sv
`timescale 1ns/1ns

module dcache_tag_store
    import dcache_pkg::*;
#(
    parameter int  index_width  = default_index_width,
    parameter int  offset_width = default_offset_width,
    localparam int tag_width    = 32 - index_width - offset_width - 2,
    localparam int num_sets     = 1 << index_width
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [index_width-1:0] rd_index,
    input  logic [tag_width-1:0]   cmp_tag,
    output logic [1:0]             hit,
    output logic                   victim,
    input  logic [index_width-1:0] wr_index,
    input  logic [tag_width-1:0]   wr_tag,
    input  logic [1:0]             tag_we,
    input  logic                   inv_set,
    input  logic                   touch,
    input  logic                   touch_way
);

    logic [tag_width-1:0]   tags [2][num_sets];
    logic [num_sets-1:0]    valid [2];
    // names the way to replace next
    logic [num_sets-1:0]    lru;

    logic [index_width-1:0] idx_q;
    logic [tag_width-1:0]   tag_q;
    logic                   valid0_q;
    logic                   valid1_q;

    ////////////////////////////////////////////////////////////
    // lookup address register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        idx_q <= rd_index;
        tag_q <= cmp_tag;
    end

    ////////////////////////////////////////////////////////////
    // tag, valid and replacement updates
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (tag_we[w]) begin
                tags[w][wr_index] <= wr_tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid[0] <= '0;
            valid[1] <= '0;
            lru      <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (tag_we[w]) begin
                    valid[w][wr_index] <= 1'b1;
                end
            end
            // invalidate wins over a refill of the same set
            if (inv_set) begin
                valid[0][wr_index] <= 1'b0;
                valid[1][wr_index] <= 1'b0;
            end
            if (touch) begin
                lru[wr_index] <= ~touch_way;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // compare and victim choice
    ////////////////////////////////////////////////////////////

    assign valid0_q = valid[0][idx_q];
    assign valid1_q = valid[1][idx_q];

    assign hit[0] = valid0_q && (tags[0][idx_q] == tag_q);
    assign hit[1] = valid1_q && (tags[1][idx_q] == tag_q);

    // an empty way is filled before anything is evicted
    assign victim = !valid0_q ? 1'b0 :
                    !valid1_q ? 1'b1 : lru[idx_q];

endmodule

//--- source/dcache_top.sv
`timescale 1ns/1ns

module dcache_top
    import dcache_pkg::*;
#(
    parameter int  index_width  = default_index_width,
    parameter int  offset_width = default_offset_width,
    localparam int tag_width    = 32 - index_width - offset_width - 2,
    localparam int line_width   = 32 << offset_width
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  cache_req_t            req,
    output logic                  req_ready,
    output logic                  resp_valid,
    output word_t                 rdata,
    output logic                  mem_req_valid,
    output mem_req_t              mem_req,
    input  logic                  mem_addr_ok,
    input  logic                  mem_data_ok,
    input  logic [line_width-1:0] mem_rdata
);

    logic [index_width-1:0]  lookup_index;
    logic [tag_width-1:0]    lookup_tag;
    logic [index_width-1:0]  wr_index;
    logic [tag_width-1:0]    wr_tag;
    logic [offset_width-1:0] wr_offset;
    word_t                   wr_word;
    strb_t                   wr_strb;
    logic [1:0]              hit;
    logic                    victim;
    logic [1:0]              tag_we;
    logic                    inv_set;
    logic                    touch;
    logic                    touch_way;
    logic [1:0]              data_word_we;
    logic [1:0]              data_line_we;
    logic [line_width-1:0]   line0;
    logic [line_width-1:0]   line1;
    logic [line_width-1:0]   hit_line;
    word_t                   hit_word;

    // word out of the hit way for the controller to register
    assign hit_line = hit[1] ? line1 : line0;
    assign hit_word = hit_line[32*wr_offset +: 32];

    dcache_ctrl #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) dcache_ctrl_inst (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .resp_valid    (resp_valid),
        .rdata         (rdata),
        .hit_word      (hit_word),
        .hit           (hit),
        .victim        (victim),
        .lookup_index  (lookup_index),
        .lookup_tag    (lookup_tag),
        .wr_index      (wr_index),
        .wr_tag        (wr_tag),
        .tag_we        (tag_we),
        .inv_set       (inv_set),
        .touch         (touch),
        .touch_way     (touch_way),
        .wr_offset     (wr_offset),
        .wr_word       (wr_word),
        .wr_strb       (wr_strb),
        .data_word_we  (data_word_we),
        .data_line_we  (data_line_we),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_addr_ok   (mem_addr_ok),
        .mem_data_ok   (mem_data_ok),
        .mem_rdata     (mem_rdata)
    );

    dcache_tag_store #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) dcache_tag_store_inst (
        .clk       (clk),
        .reset     (reset),
        .rd_index  (lookup_index),
        .cmp_tag   (lookup_tag),
        .hit       (hit),
        .victim    (victim),
        .wr_index  (wr_index),
        .wr_tag    (wr_tag),
        .tag_we    (tag_we),
        .inv_set   (inv_set),
        .touch     (touch),
        .touch_way (touch_way)
    );

    // refill data comes straight from the memory port
    dcache_data_store #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) dcache_data_store_inst (
        .clk       (clk),
        .rd_index  (lookup_index),
        .line0     (line0),
        .line1     (line1),
        .wr_index  (wr_index),
        .wr_offset (wr_offset),
        .wr_word   (wr_word),
        .wr_strb   (wr_strb),
        .word_we   (data_word_we),
        .line_we   (data_line_we),
        .wr_line   (mem_rdata)
    );

endmodule

//--- testbench/dcache_mem_model.sv
`timescale 1ns/1ns

module dcache_mem_model
    import dcache_pkg::*;
#(
    parameter int  index_width  = default_index_width,
    parameter int  offset_width = default_offset_width,
    localparam int line_width   = 32 << offset_width,
    localparam int line_words   = 1 << offset_width,
    localparam int mem_words    = 1024
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  mem_req_valid,
    input  mem_req_t              mem_req,
    output logic                  mem_addr_ok,
    output logic                  mem_data_ok,
    output logic [line_width-1:0] mem_rdata
);

    word_t      mem [mem_words];
    mem_req_t   held;
    logic [9:0] word_idx;
    int         seed;

    // every word starts out as a function of its byte address
    function automatic word_t fill_pattern(input addr_t a);
        return (a * 32'h2545f491) ^ 32'h6d2b79f5;
    endfunction

    // zero to four idle cycles before a strobe
    task automatic random_wait();
        int gap;
        gap = {$random(seed)} % 5;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        seed        = 32'h789c3bca;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = fill_pattern(addr_t'(i) << 2);
        end
        forever begin
            @(posedge clk);
            #1;
            if (!reset && mem_req_valid) begin
                held     = mem_req;
                word_idx = held.addr[11:2];
                random_wait();
                mem_addr_ok = 1'b1;
                @(posedge clk);
                #1;
                mem_addr_ok = 1'b0;
                random_wait();
                mem_rdata = '0;
                if (held.write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (held.wstrb[b]) begin
                            mem[word_idx][8*b +: 8] = held.wdata[8*b +: 8];
                        end
                    end
                end else if (held.line) begin
                    for (int w = 0; w < line_words; w++) begin
                        mem_rdata[32*w +: 32] = mem[word_idx + 10'(w)];
                    end
                end else begin
                    // single word in the low lane
                    mem_rdata[31:0] = mem[word_idx];
                end
                mem_data_ok = 1'b1;
                @(posedge clk);
                #1;
                mem_data_ok = 1'b0;
            end
        end
    end

endmodule

//--- testbench/dcache_sva.sv
`timescale 1ns/1ns

module dcache_sva
    import dcache_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       req_valid,
    input logic       req_ready,
    input cache_req_t req,
    input logic       resp_valid,
    input logic [1:0] hit,
    input logic       is_write,
    input logic       mem_req_valid,
    input mem_req_t   mem_req,
    input logic       mem_addr_ok,
    input logic       mem_data_ok
);

    int error_count = 0;

    ////////////////////////////////////////////////////////////
    // memory side
    ////////////////////////////////////////////////////////////

    // request holds until the memory takes it
    hold_mem_req: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_addr_ok |=> mem_req_valid && $stable(mem_req))
    else begin
        $error("memory request changed before mem_addr_ok");
        error_count++;
    end

    ////////////////////////////////////////////////////////////
    // pipeline side
    ////////////////////////////////////////////////////////////

    // a finished write goes back to ready with no response
    write_no_resp: assert property (@(posedge clk) disable iff (reset)
        mem_data_ok && is_write |=> req_ready && !resp_valid)
    else begin
        $error("write completion produced a response or no ready");
        error_count++;
    end

    // a lookup hit responds on the next edge
    hit_latency: assert property (@(posedge clk) disable iff (reset)
        (|hit) && $past(req_valid && req_ready && req.kind == kind_read && !req.uncached)
        |=> resp_valid)
    else begin
        $error("read hit did not respond two edges after acceptance");
        error_count++;
    end

endmodule

bind dcache_ctrl dcache_sva dcache_sva_inst (
    .clk           (clk),
    .reset         (reset),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req           (req),
    .resp_valid    (resp_valid),
    .hit           (hit),
    .is_write      (is_write),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_addr_ok   (mem_addr_ok),
    .mem_data_ok   (mem_data_ok)
);

//--- testbench/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb
    import dcache_pkg::*;
();

    // four sets of four words so lines 64 bytes apart share a set
    localparam int    index_width  = 2;
    localparam int    offset_width = 2;
    localparam int    line_width   = 32 << offset_width;
    localparam int    mem_words    = 1024;
    localparam int    max_cycles   = 4000;
    localparam addr_t offset_mask  = addr_t'((1 << (offset_width + 2)) - 1);

    logic                  clk;
    logic                  reset;
    logic                  req_valid;
    cache_req_t            req;
    logic                  req_ready;
    logic                  resp_valid;
    word_t                 rdata;
    logic                  mem_req_valid;
    mem_req_t              mem_req;
    logic                  mem_addr_ok;
    logic                  mem_data_ok;
    logic [line_width-1:0] mem_rdata;

    word_t      shadow [mem_words];
    cache_req_t cur_req;
    int         fill_count = 0;
    int         mem_count  = 0;
    int         resp_count = 0;
    int         cycles     = 0;

    dcache_top #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) dcache_top_inst (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .resp_valid    (resp_valid),
        .rdata         (rdata),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_addr_ok   (mem_addr_ok),
        .mem_data_ok   (mem_data_ok),
        .mem_rdata     (mem_rdata)
    );

    dcache_mem_model #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) dcache_mem_model_inst (
        .clk           (clk),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_addr_ok   (mem_addr_ok),
        .mem_data_ok   (mem_data_ok),
        .mem_rdata     (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic word_t fill_pattern(input addr_t a);
        return (a * 32'h2545f491) ^ 32'h6d2b79f5;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    ////////////////////////////////////////////////////////////
    // monitors
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            abort_run($sformatf("run went past %0d cycles without finishing", max_cycles));
        end
    end

    always @(negedge clk) begin
        if (!reset && mem_req_valid && mem_addr_ok) begin
            mem_count++;
            if (mem_req.line) begin
                fill_count++;
            end
            if (cur_req.kind == kind_invalidate) begin
                abort_run("an invalidate reached the memory port");
            end else if (cur_req.kind == kind_write) begin
                assert (mem_req.write && !mem_req.line && mem_req.addr == cur_req.addr &&
                        mem_req.wdata == cur_req.wdata && mem_req.wstrb == cur_req.wstrb)
                else abort_run($sformatf("Mismatch at %0t: write request for %h is wrong",
                                         $time, cur_req.addr));
            end else begin
                // cached reads fetch the whole line
                assert (!mem_req.write && mem_req.line == !cur_req.uncached &&
                        mem_req.addr == (cur_req.uncached ? cur_req.addr :
                                         (cur_req.addr & ~offset_mask)))
                else abort_run($sformatf("Mismatch at %0t: read request for %h is wrong",
                                         $time, cur_req.addr));
            end
        end
        if (resp_valid) begin
            resp_count++;
            assert (cur_req.kind == kind_read)
            else abort_run("a response came for a request that was not a read");
            assert (rdata == shadow[cur_req.addr[11:2]])
            else abort_run($sformatf("Mismatch at %0t: read of %h gave %h, expected %h",
                                     $time, cur_req.addr, rdata,
                                     shadow[cur_req.addr[11:2]]));
        end
        if (dcache_top_inst.dcache_ctrl_inst.dcache_sva_inst.error_count != 0) begin
            abort_run("a protocol assertion failed");
        end
    end

    ////////////////////////////////////////////////////////////
    // request tasks
    ////////////////////////////////////////////////////////////

    // one request from acceptance until ready comes back
    task automatic issue(input req_kind_e kind, input logic uncached, input addr_t addr,
                         input word_t wdata, input strb_t wstrb);
        int resps_before;
        int resps_expected;
        resps_before     = resp_count;
        resps_expected   = (kind == kind_read) ? 1 : 0;
        cur_req.kind     = kind;
        cur_req.uncached = uncached;
        cur_req.addr     = addr;
        cur_req.wdata    = wdata;
        cur_req.wstrb    = wstrb;
        req              = cur_req;
        req_valid        = 1'b1;
        while (!req_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        if (kind == kind_write) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    shadow[addr[11:2]][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
        while (!req_ready) begin
            @(posedge clk);
            #1;
        end
        // only reads answer, and each exactly once
        assert (resp_count - resps_before == resps_expected)
        else abort_run($sformatf("Mismatch at %0t: %h got %0d responses, expected %0d",
                                 $time, addr, resp_count - resps_before, resps_expected));
    endtask

    task automatic access_and_count(input req_kind_e kind, input logic uncached,
                                    input addr_t addr, input word_t wdata, input strb_t wstrb,
                                    input int fills, input int mems, input string what);
        int fills_before;
        int mems_before;
        fills_before = fill_count;
        mems_before  = mem_count;
        issue(kind, uncached, addr, wdata, wstrb);
        assert (fill_count - fills_before == fills && mem_count - mems_before == mems)
        else abort_run($sformatf(
            "Mismatch at %0t: %s saw %0d fills, %0d requests, expected %0d, %0d",
            $time, what, fill_count - fills_before, mem_count - mems_before, fills, mems));
    endtask

    task automatic read_word(input addr_t addr, input logic uncached, input int fills,
                             input int mems, input string what);
        access_and_count(kind_read, uncached, addr, '0, '0, fills, mems, what);
    endtask

    task automatic write_word(input addr_t addr, input logic uncached, input word_t data,
                              input strb_t strb, input string what);
        access_and_count(kind_write, uncached, addr, data, strb, 0, 1, what);
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        cur_req   = '0;
        for (int i = 0; i < mem_words; i++) begin
            shadow[i] = fill_pattern(addr_t'(i) << 2);
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        read_word(32'h0000_0100, 1'b0, 1, 1, "first read of a line");
        read_word(32'h0000_010c, 1'b0, 0, 0, "second read of that line");

        // partial write hit and a read of the merged bytes
        write_word(32'h0000_0104, 1'b0, 32'hdead_beef, 4'b0101, "write hit");
        read_word(32'h0000_0104, 1'b0, 0, 0, "read after write hit");

        // no write allocate
        write_word(32'h0000_0214, 1'b0, 32'h1234_5678, 4'b1110, "write miss");
        read_word(32'h0000_0214, 1'b0, 1, 1, "read after write miss");

        read_word(32'h0000_0320, 1'b1, 0, 1, "uncached read");
        read_word(32'h0000_0324, 1'b0, 1, 1, "cached read after uncached");
        write_word(32'h0000_03c4, 1'b1, 32'h0bad_cafe, 4'b1100, "uncached write");
        read_word(32'h0000_03c4, 1'b1, 0, 1, "uncached read after write");

        // set 3 holds A and B and a miss on C after a hit on A evicts B
        read_word(32'h0000_0030, 1'b0, 1, 1, "fill of A");
        read_word(32'h0000_0070, 1'b0, 1, 1, "fill of B");
        read_word(32'h0000_0034, 1'b0, 0, 0, "hit on A");
        read_word(32'h0000_00b0, 1'b0, 1, 1, "fill of C");
        read_word(32'h0000_0038, 1'b0, 0, 0, "A after C");
        read_word(32'h0000_0074, 1'b0, 1, 1, "B after C");

        // both ways of set 0 hold a line before the invalidate
        read_word(32'h0000_0140, 1'b0, 1, 1, "second line of set 0");
        access_and_count(kind_invalidate, 1'b0, 32'h0000_0100, '0, '0, 0, 0, "invalidate");
        read_word(32'h0000_0108, 1'b0, 1, 1, "read after invalidate");
        read_word(32'h0000_0100, 1'b0, 0, 0, "read after refill");
        read_word(32'h0000_0148, 1'b0, 1, 1, "other way after invalidate");

        // mixed writes and reads over many sets
        for (int i = 0; i < 16; i++) begin
            issue(kind_write, 1'b0, 32'h0000_0400 + 32'(i * 52),
                  32'h0101_0101 * word_t'(i + 1), strb_t'(i) | 4'b0001);
            issue(kind_read, 1'b0, 32'h0000_0400 + 32'(i * 52), '0, '0);
        end

        if (dcache_top_inst.dcache_ctrl_inst.dcache_sva_inst.error_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abort_run("a protocol assertion failed");
        end
    end

endmodule
